// ==== project.f ====
design/ComPkg.sv
design/SpiReceiver.sv
design/ServiceUnpacker.sv
design/ComControl.sv
design/StatusInfo.sv
design/BusPusher.sv
design/ResetGenerator.sv
design/CommunicationBlock.sv
dv/CommunicationBlockTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module CommunicationBlockTb \
	-f project.f --Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "No errors"; then
	exit 0
fi
exit 1

// ==== dv/CommunicationBlockTb.sv ====
`timescale 1ns/1ps

module CommunicationBlockTb;
	import ComPkg::*;

	typedef TWord TWordQueue[$];

	localparam int MaxCycles = 20000; // Whole run needs about 2500 cycles.
	localparam logic [7:0] OwnAddr = 8'h3c;
	localparam TPacketStatus GoodPacket = '{packetStart: 1'b1, packetEnd: 1'b1, packetErr: 1'b0};
	localparam TPacketStatus BadHeader  = '{packetStart: 1'b0, packetEnd: 1'b0, packetErr: 1'b1};
	localparam TPacketStatus BadLength  = '{packetStart: 1'b1, packetEnd: 1'b0, packetErr: 1'b1};

	logic         clk;
	logic         rst;
	logic         resetRequest;
	logic         spiSclk;
	logic         spiMosi;
	logic         spiCs;
	logic [7:0]   ownAddr;
	logic         txDone;
	TWord         rxWord;
	logic         rxValid;
	TPacketStatus packetStatus;
	TWord         txWord;
	logic         txRequest;

	TWord rxWords[$];
	TWord txWords[$];
	int   startCnt = 0;
	int   endCnt = 0;
	int   errCnt = 0;
	int   cycleCount = 0;
	int   errors = 0;
	int   modelGood = 0; // Expected DUT counters.
	int   modelErr = 0;
	TWord modelLast = '0;

	CommunicationBlock uut (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) cycleCount = cycleCount + 1;

	initial begin
		wait (cycleCount == MaxCycles);
		$display("Timeout: run still going after %0d cycles", MaxCycles);
		$display("Errors found");
		$finish;
	end

	// Sampled mid-cycle.
	always @(negedge clk) begin
		if (rxValid) rxWords.push_back(rxWord);
		if (packetStatus.packetStart) startCnt++;
		if (packetStatus.packetEnd) endCnt++;
		if (packetStatus.packetErr) errCnt++;
	end

	// Push port partner with a random latency.
	initial begin
		int delay;
		txDone = 1'b0;
		forever begin
			@(negedge clk);
			if (txRequest) begin
				txWords.push_back(txWord);
				delay = $urandom_range(5, 0);
				waitCycles(delay + 1);
				txDone = 1'b1;
				waitCycles(1);
				txDone = 1'b0;
			end
		end
	end

	task automatic waitCycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
		end
	endtask

	function automatic TWord makeHeader(input logic [7:0] addr, input logic [3:0] cmd,
		input logic [3:0] count);
		TSpiWord w;
		w.header.moduleAddr = addr;
		w.header.cmdCode    = TCommandCode'(cmd);
		w.header.wordCount  = count;
		return w.data;
	endfunction

	task automatic checkWord(input string name, input TWord expected, input TWord actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic checkStatus(input string name, input TPacketStatus expected,
		input TPacketStatus actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected status %b, actual %b", name, expected, actual);
			errors++;
		end
	endtask

	task automatic checkCount(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("ERROR %s: expected count %0d, actual %0d", name, expected, actual);
			errors++;
		end
	endtask

	// MSB first, cs held low for the whole packet.
	task automatic sendPacket(input TWordQueue words);
		spiCs = 1'b0;
		foreach (words[i])
			for (int b = 15; b >= 0; b--) begin
				spiMosi = words[i][b];
				waitCycles(4);
				spiSclk = 1'b1;
				waitCycles(4);
				spiSclk = 1'b0;
			end
		waitCycles(4);
		spiCs = 1'b1;
		waitCycles(4);
	endtask

	task automatic runPacket(input string name, input TWordQueue words,
		input TPacketStatus expected, input int expectedRx);
		int           startBase;
		int           endBase;
		int           errBase;
		int           rxBase;
		int           waited;
		TPacketStatus seen;
		startBase = startCnt;
		endBase   = endCnt;
		errBase   = errCnt;
		rxBase    = rxWords.size();
		sendPacket(words);
		waited = 0;
		while (endCnt == endBase && errCnt == errBase && waited < 20) begin
			waitCycles(1);
			waited++;
		end
		if (endCnt == endBase && errCnt == errBase) begin
			$display("%s: no packet end or error strobe after cs went high", name);
			errors++;
		end
		seen.packetStart = (startCnt != startBase);
		seen.packetEnd   = (endCnt != endBase);
		seen.packetErr   = (errCnt != errBase);
		checkStatus(name, expected, seen);
		checkCount(name, expectedRx, rxWords.size() - rxBase);
	endtask

	task automatic writePacket();
		TWordQueue pkt;
		TWord      hdr;
		int        base;
		hdr = makeHeader(OwnAddr, CMD_WRITE, 4'd3);
		pkt.push_back(hdr);
		repeat (3) pkt.push_back(TWord'($urandom));
		base = rxWords.size();
		runPacket("writePacket", pkt, GoodPacket, 3);
		for (int i = 1; i < 4; i++)
			if (rxWords.size() >= base + i)
				checkWord("writePacket", pkt[i], rxWords[base + i - 1]);
		modelGood++;
		modelLast = hdr;
	endtask

	task automatic wrongAddress();
		TWordQueue pkt;
		pkt.push_back(makeHeader(OwnAddr ^ 8'h5a, CMD_WRITE, 4'd2));
		pkt.push_back(TWord'($urandom));
		pkt.push_back(TWord'($urandom));
		runPacket("wrongAddress", pkt, BadHeader, 0);
		pkt[0] = makeHeader(OwnAddr, 4'd7, 4'd2); // No such command.
		runPacket("wrongAddress", pkt, BadHeader, 0);
		modelErr += 2;
	endtask

	task automatic wrongLength();
		TWordQueue pkt;
		pkt.push_back(makeHeader(OwnAddr, CMD_WRITE, 4'd2));
		pkt.push_back(TWord'($urandom));
		runPacket("wrongLength", pkt, BadLength, 1);
		modelErr++;
	endtask

	// Reply shows the counters from before this packet.
	task automatic statusRead(input string name);
		TWordQueue pkt;
		TWord      hdr;
		TWord      expected0;
		int        base;
		int        waited;
		hdr = makeHeader(OwnAddr, CMD_STATUS, 4'd0);
		pkt.push_back(hdr);
		expected0 = {modelGood[7:0], modelErr[7:0]};
		base = txWords.size();
		runPacket(name, pkt, GoodPacket, 0);
		waited = 0;
		while (txWords.size() < base + 2 && waited < 200) begin
			waitCycles(1);
			waited++;
		end
		waitCycles(20); // Room for a stray third transfer.
		if (txWords.size() < base + 2) begin
			$display("%s: status reply sent %0d of 2 words", name, txWords.size() - base);
			errors++;
		end else begin
			checkCount(name, 2, txWords.size() - base);
			checkWord(name, expected0, txWords[base]);
			checkWord(name, modelLast, txWords[base + 1]);
		end
		modelGood++;
		modelLast = hdr;
	endtask

	task automatic resetFilter();
		resetRequest = 1'b1;
		waitCycles(2);
		resetRequest = 1'b0;
		waitCycles(10);
		statusRead("resetRequest short");
		resetRequest = 1'b1;
		waitCycles(5);
		resetRequest = 1'b0;
		waitCycles(ResetPause + ResetFilterLen + 5);
		modelGood = 0;
		modelErr  = 0;
		modelLast = '0;
		statusRead("resetRequest long");
	endtask

	initial begin
		void'($urandom(32684));
		rst          = 1'b1;
		resetRequest = 1'b0;
		spiSclk      = 1'b0;
		spiMosi      = 1'b0;
		spiCs        = 1'b1;
		ownAddr      = OwnAddr;
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;
		waitCycles(4);
		writePacket();
		wrongAddress();
		wrongLength();
		statusRead("statusRead");
		resetFilter();
		$display("Run complete with %0d errors", errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== design/CommunicationBlock.sv ====
`timescale 1ns/1ps

module CommunicationBlock (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 resetRequest,
	input  logic                 spiSclk,
	input  logic                 spiMosi,
	input  logic                 spiCs,
	input  logic [7:0]           ownAddr,
	input  logic                 txDone,
	output ComPkg::TWord         rxWord,
	output logic                 rxValid,
	output ComPkg::TPacketStatus packetStatus,
	output ComPkg::TWord         txWord,
	output logic                 txRequest
);
	import ComPkg::*;

	logic        coreRst;
	TWord        word;
	logic        wordValid;
	logic        packetClose;
	THeader      header;
	TStatusWords statusWords;
	logic        startReply;
	logic        popRequest;
	TWord        popData;
	logic        popDone;
	logic        last;

	ResetGenerator resetGen (.clk(clk), .rst(rst), .resetRequest(resetRequest),
		.coreRst(coreRst));

	SpiReceiver spiRx (.clk(clk), .rst(coreRst), .spiSclk(spiSclk), .spiMosi(spiMosi),
		.spiCs(spiCs), .word(word), .wordValid(wordValid), .packetClose(packetClose));

	ServiceUnpacker unpacker (.clk(clk), .rst(coreRst), .ownAddr(ownAddr), .word(word),
		.wordValid(wordValid), .packetClose(packetClose), .rxWord(rxWord), .rxValid(rxValid),
		.packetStatus(packetStatus), .header(header));

	ComControl control (.clk(clk), .rst(coreRst), .packetStatus(packetStatus),
		.header(header), .statusWords(statusWords), .startReply(startReply));

	StatusInfo statusInfo (.clk(clk), .rst(coreRst), .statusWords(statusWords),
		.popRequest(popRequest), .popData(popData), .popDone(popDone), .last(last));

	BusPusher pusher (.clk(clk), .rst(coreRst), .startReply(startReply),
		.popRequest(popRequest), .popData(popData), .popDone(popDone), .last(last),
		.txWord(txWord), .txRequest(txRequest), .txDone(txDone));

endmodule

// ==== design/ResetGenerator.sv ====
`timescale 1ns/1ps

module ResetGenerator (
	input  logic clk,
	input  logic rst,
	input  logic resetRequest,
	output logic coreRst
);
	import ComPkg::*;

	typedef logic [$clog2(ResetPause + 1) - 1:0] TPauseCnt;

	logic [ResetFilterLen - 1:0] filter;
	TPauseCnt                    pauseCnt;

	assign coreRst = rst || (pauseCnt != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			filter   <= '0;
			pauseCnt <= '0;
		end else begin
			filter <= {filter[ResetFilterLen - 2:0], resetRequest};
			if (&filter)
				pauseCnt <= TPauseCnt'(ResetPause); // Retriggers while request stays high.
			else if (pauseCnt != '0)
				pauseCnt <= pauseCnt - TPauseCnt'(1);
		end
	end

	assert property (@(posedge clk) rst |-> coreRst)
		else $error("ResetGenerator: core left running during external reset");

endmodule

// ==== design/BusPusher.sv ====
`timescale 1ns/1ps

module BusPusher (
	input  logic         clk,
	input  logic         rst,
	input  logic         startReply,
	output logic         popRequest,
	input  ComPkg::TWord popData,
	input  logic         popDone,
	input  logic         last,
	output ComPkg::TWord txWord,
	output logic         txRequest,
	input  logic         txDone
);

	typedef enum logic [2:0] {IDLE, READ_REQ, READ_WAIT, WRITE_REQ, WRITE_WAIT} TState;

	TState state;
	TState next;
	logic  lastWord;

	assign popRequest = (state == READ_REQ);
	assign txRequest  = (state == WRITE_REQ);

	always_ff @(posedge clk)
		if (rst)
			state <= IDLE;
		else
			state <= next;

	always_comb begin
		next = state;
		unique case (state)
			IDLE:       if (startReply) next = READ_REQ;
			READ_REQ:   next = READ_WAIT;
			READ_WAIT:  if (popDone) next = WRITE_REQ;
			WRITE_REQ:  next = WRITE_WAIT;
			WRITE_WAIT: if (txDone) next = lastWord ? IDLE : READ_REQ;
			default:    next = IDLE;
		endcase
	end

	always_ff @(posedge clk)
		if (state == READ_WAIT && popDone) begin
			txWord   <= popData;
			lastWord <= last;
		end

	// Word held from the push request until the far side takes it.
	assert property (@(posedge clk) disable iff (rst)
		(txRequest || (state == WRITE_WAIT && !txDone)) |=> $stable(txWord))
		else $error("BusPusher: txWord changed before txDone");

endmodule

// ==== design/StatusInfo.sv ====
`timescale 1ns/1ps

module StatusInfo (
	input  logic                clk,
	input  logic                rst,
	input  ComPkg::TStatusWords statusWords,
	input  logic                popRequest,
	output ComPkg::TWord        popData,
	output logic                popDone,
	output logic                last
);

	typedef enum logic [1:0] {IDLE, SEND0, WAIT1, SEND1} TState;

	TState state;
	TState next;

	always_ff @(posedge clk)
		if (rst)
			state <= IDLE;
		else
			state <= next;

	always_comb begin
		next = state;
		unique case (state)
			IDLE:    if (popRequest) next = SEND0;
			SEND0:   next = WAIT1;
			WAIT1:   if (popRequest) next = SEND1;
			SEND1:   next = IDLE;
			default: next = IDLE;
		endcase
	end

	assign popDone = (state == SEND0) || (state == SEND1); // One cycle after request.
	assign last    = (state == SEND1);
	assign popData = (state == SEND1) ? statusWords.statusWord1 : statusWords.statusWord0;

endmodule

// ==== design/ComControl.sv ====
`timescale 1ns/1ps

module ComControl (
	input  logic                 clk,
	input  logic                 rst,
	input  ComPkg::TPacketStatus packetStatus,
	input  ComPkg::THeader       header,
	output ComPkg::TStatusWords  statusWords,
	output logic                 startReply
);
	import ComPkg::*;

	logic [7:0] goodCnt;
	logic [7:0] errCnt;
	THeader     lastHeader;

	always_ff @(posedge clk) begin
		if (rst) begin
			goodCnt     <= '0;
			errCnt      <= '0;
			lastHeader  <= '0;
			statusWords <= '0;
			startReply  <= 1'b0;
		end else begin
			startReply <= 1'b0;
			if (packetStatus.packetErr && errCnt != 8'hff)
				errCnt <= errCnt + 8'd1;
			if (packetStatus.packetEnd) begin
				// Snapshot taken before this packet is counted.
				if (header.cmdCode == CMD_STATUS) begin
					startReply              <= 1'b1;
					statusWords.statusWord0 <= {goodCnt, errCnt};
					statusWords.statusWord1 <= TWord'(lastHeader);
				end
				if (goodCnt != 8'hff)
					goodCnt <= goodCnt + 8'd1;
				lastHeader <= header;
			end
		end
	end

endmodule

// ==== design/ServiceUnpacker.sv ====
`timescale 1ns/1ps

module ServiceUnpacker (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [7:0]           ownAddr,
	input  ComPkg::TWord         word,
	input  logic                 wordValid,
	input  logic                 packetClose,
	output ComPkg::TWord         rxWord,
	output logic                 rxValid,
	output ComPkg::TPacketStatus packetStatus,
	output ComPkg::THeader       header
);
	import ComPkg::*;

	TSpiWord    inWord;
	logic       headerSeen;
	logic       packetGood;
	logic [4:0] dataCnt; // One bit wider than wordCount to catch overruns.
	logic       headerOk;
	logic       inCount;

	assign inWord.data = word;
	assign headerOk = (inWord.header.moduleAddr == ownAddr) &&
		(inWord.header.cmdCode inside {CMD_WRITE, CMD_STATUS});
	assign inCount = (dataCnt < {1'b0, header.wordCount});

	always_ff @(posedge clk) begin
		if (rst) begin
			headerSeen   <= 1'b0;
			packetGood   <= 1'b0;
			dataCnt      <= '0;
			header       <= '0;
			rxValid      <= 1'b0;
			packetStatus <= '0;
		end else begin
			rxValid      <= 1'b0;
			packetStatus <= '0;
			if (packetClose) begin
				headerSeen <= 1'b0;
				if (headerSeen && packetGood && dataCnt == {1'b0, header.wordCount})
					packetStatus.packetEnd <= 1'b1;
				else
					packetStatus.packetErr <= 1'b1;
			end else if (wordValid) begin
				if (!headerSeen) begin
					headerSeen               <= 1'b1;
					packetGood               <= headerOk;
					dataCnt                  <= '0;
					header                   <= inWord.header;
					packetStatus.packetStart <= headerOk;
				end else begin
					if (dataCnt != '1)
						dataCnt <= dataCnt + 5'd1;
					// Only write data within the announced length goes out.
					rxValid <= packetGood && header.cmdCode == CMD_WRITE && inCount;
				end
			end
		end
	end

	always_ff @(posedge clk)
		if (wordValid && headerSeen)
			rxWord <= inWord.data;

	// Every close ends in exactly one outcome strobe.
	assert property (@(posedge clk) disable iff (rst)
		packetClose |=> (packetStatus.packetEnd != packetStatus.packetErr))
		else $error("ServiceUnpacker: packet outcome not unique");

endmodule

// ==== design/SpiReceiver.sv ====
`timescale 1ns/1ps

module SpiReceiver (
	input  logic         clk,
	input  logic         rst,
	input  logic         spiSclk,
	input  logic         spiMosi,
	input  logic         spiCs,
	output ComPkg::TWord word,
	output logic         wordValid,
	output logic         packetClose
);
	import ComPkg::*;

	logic [2:0] sclkSync;
	logic [2:0] csSync;
	logic [1:0] mosiSync;
	logic [3:0] bitCnt;
	TWord       shiftReg;
	logic       sclkRise;
	logic       csRise;
	logic       csActive;

	assign sclkRise = (sclkSync[2:1] == 2'b01);
	assign csRise   = (csSync[2:1] == 2'b01);
	assign csActive = !csSync[1]; // Low on the cycle cs rises, so no shift then.

	always_ff @(posedge clk) begin
		if (rst) begin
			sclkSync <= '0;
			csSync   <= '1;
		end else begin
			sclkSync <= {sclkSync[1:0], spiSclk};
			csSync   <= {csSync[1:0], spiCs};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			bitCnt      <= '0;
			wordValid   <= 1'b0;
			packetClose <= 1'b0;
		end else begin
			wordValid   <= 1'b0;
			packetClose <= csRise;
			if (csRise)
				bitCnt <= '0; // Partial word is dropped.
			else if (csActive && sclkRise) begin
				bitCnt    <= bitCnt + 4'd1;
				wordValid <= (bitCnt == 4'd15);
			end
		end
	end

	// Mosi goes through the same depth as sclk.
	always_ff @(posedge clk) begin
		mosiSync <= {mosiSync[0], spiMosi};
		if (csActive && sclkRise) begin
			shiftReg <= {shiftReg[14:0], mosiSync[1]};
			if (bitCnt == 4'd15)
				word <= {shiftReg[14:0], mosiSync[1]};
		end
	end

	assert property (@(posedge clk) disable iff (rst) !(wordValid && packetClose))
		else $error("SpiReceiver: word completed on packet close");

endmodule

// ==== design/ComPkg.sv ====
package ComPkg;

	typedef logic [15:0] TWord;

	// Anything else in the command field is rejected.
	typedef enum logic [3:0] {
		CMD_WRITE  = 4'd1,
		CMD_STATUS = 4'd2
	} TCommandCode;

	typedef struct packed {
		logic [7:0]  moduleAddr;
		TCommandCode cmdCode;
		logic [3:0]  wordCount; // Data words after the header.
	} THeader;

	// First word of a packet is a header, the rest are data.
	typedef union packed {
		TWord   data;
		THeader header;
	} TSpiWord;

	typedef struct packed {
		logic packetStart;
		logic packetEnd;
		logic packetErr;
	} TPacketStatus;

	// Word 0 is {good count, error count}, word 1 the last good header.
	typedef struct packed {
		TWord statusWord0;
		TWord statusWord1;
	} TStatusWords;

	localparam int ResetFilterLen = 3;
	localparam int ResetPause     = 15;

endpackage
